//--- vlog.f
+incdir+include
logic/isaPkg.sv
logic/busPkg.sv
logic/fetchUnit.sv
logic/controlUnit.sv
logic/registerFile.sv
logic/hazardUnit.sv
logic/busArbiter.sv
logic/sharedMemory.sv
logic/pipeCore.sv
logic/mipsSystem.sv
tb/mipsSystemTb.sv

//--- Makefile
.PHONY: sim clean

sim:
	verilator --binary --timing --assert --top-module mipsSystemTb -f vlog.f -Mdir obj_dir
	./obj_dir/VmipsSystemTb

clean:
	rm -rf obj_dir

//--- tb/mipsSystemTb.sv
`timescale 1ns/1ps
`include "mipsConfig_config.svh"

module mipsSystemTb;

	// Program and data layout
	localparam int PROG_LEN = 60;
	localparam int PAD_WORDS = 4;
	localparam int DATA_WORDS = 32;
	localparam int DATA_BASE = `MEM_WORDS / 2;
	localparam int QUIET_CYCLES = 100;

	logic clk;
	logic reset;
	logic start;
	logic loadCyc;
	logic loadStb;
	logic loadWe;
	busPkg::busAddr_t loadAdr;
	busPkg::busData_t loadDatW;
	busPkg::busData_t loadDatR;
	logic loadAck;
	logic wbValid;
	isaPkg::regAddr_t wbReg;
	isaPkg::word_t wbData;

	// Random source and run bookkeeping
	logic [31:0] lfsr = 32'h4961_c0c7;
	int unsigned budget = 200;
	int unsigned elapsed = 0;
	string testName = "reset";

	// Program image, model state, expected write-backs
	isaPkg::word_t prog[$];
	isaPkg::word_t modelRegs [32];
	isaPkg::word_t modelMem [DATA_WORDS];
	isaPkg::regAddr_t expReg[$];
	isaPkg::word_t expData[$];

	mipsSystem mipsSystem_i
	(
		.clk(clk),
		.reset(reset),
		.start(start),
		.loadCyc(loadCyc),
		.loadStb(loadStb),
		.loadWe(loadWe),
		.loadAdr(loadAdr),
		.loadDatW(loadDatW),
		.loadDatR(loadDatR),
		.loadAck(loadAck),
		.wbValid(wbValid),
		.wbReg(wbReg),
		.wbData(wbData)
	);

	initial
	begin
		clk = 1'b0;
		forever
			#2 clk = ~clk;
	end

	// ---------------------------------------------------------------------------
	// Random numbers, reporting, watchdog
	// ---------------------------------------------------------------------------

	// Taps 32, 22, 2, 1, one step per bit
	function automatic logic [31:0] randBits(input int n);
		logic [31:0] r;
		logic fb;
		r = '0;
		for (int i = 0; i < n; i++)
		begin
			fb = lfsr[31] ^ lfsr[21] ^ lfsr[1] ^ lfsr[0];
			lfsr = {lfsr[30:0], fb};
			r = {r[30:0], fb};
		end
		return r;
	endfunction

	task automatic failRun(input string why);
		$display("%s", why);
		$display("Test FAILED");
		$fatal(1, "simulation stopped");
	endtask

	task automatic checkWord(input string what, input isaPkg::word_t expected,
		input isaPkg::word_t actual);
		if (actual !== expected)
			failRun($sformatf("error %s %s: expected %h, actual %h",
				testName, what, expected, actual));
	endtask

	task automatic checkReg(input string what, input isaPkg::regAddr_t expected,
		input isaPkg::regAddr_t actual);
		if (actual !== expected)
			failRun($sformatf("error %s %s: expected %0d, actual %0d",
				testName, what, expected, actual));
	endtask

	task automatic armWatchdog(input int unsigned cycles);
		budget = cycles;
		elapsed = 0;
	endtask

	initial
	begin
		forever
		begin
			@(posedge clk);
			elapsed++;
			if (elapsed > budget)
				failRun($sformatf("%s did not finish within %0d clock cycles",
					testName, budget));
		end
	end

	// Every retirement must match the head of the model queue
	always @(negedge clk)
	begin
		if (!reset && wbValid)
		begin
			if (expReg.size() == 0)
				failRun($sformatf("%s wrote register %0d when nothing was left to retire",
					testName, wbReg));
			else
			begin
				checkReg("wb register", expReg[0], wbReg);
				checkWord("wb data", expData[0], wbData);
				void'(expReg.pop_front());
				void'(expData.pop_front());
			end
		end
	end

	// ---------------------------------------------------------------------------
	// Loader master
	// ---------------------------------------------------------------------------

	task automatic loaderCycle(input logic we, input busPkg::busAddr_t adr,
		input busPkg::busData_t datW, output busPkg::busData_t datR);
		@(negedge clk);
		loadCyc = 1'b1;
		loadStb = 1'b1;
		loadWe = we;
		loadAdr = adr;
		loadDatW = datW;
		do
			@(negedge clk);
		while (!loadAck);
		datR = loadDatR;
		// Request stays up across the ack edge
		@(negedge clk);
		loadCyc = 1'b0;
		loadStb = 1'b0;
		loadWe = 1'b0;
	endtask

	function automatic busPkg::busAddr_t dataAddr(input int k);
		return busPkg::busAddr_t'((DATA_BASE + k) * 4);
	endfunction

	// Whole data window against the model
	task automatic checkDataRegion();
		busPkg::busData_t got;
		for (int k = 0; k < DATA_WORDS; k++)
		begin
			loaderCycle(1'b0, dataAddr(k), '0, got);
			checkWord($sformatf("data word %0d", k), modelMem[k], got);
		end
	endtask

	task automatic applyReset();
		@(negedge clk);
		reset = 1'b1;
		repeat (4) @(negedge clk);
		reset = 1'b0;
	endtask

	// ---------------------------------------------------------------------------
	// Program generation
	// ---------------------------------------------------------------------------

	function automatic isaPkg::word_t encR(input isaPkg::regAddr_t rs,
		input isaPkg::regAddr_t rt, input isaPkg::regAddr_t rd, input isaPkg::funct_t fn);
		return {isaPkg::OP_RTYPE, rs, rt, rd, 5'd0, fn};
	endfunction

	function automatic isaPkg::word_t encI(input isaPkg::opcode_t op,
		input isaPkg::regAddr_t rs, input isaPkg::regAddr_t rt, input logic [15:0] imm);
		return {op, rs, rt, imm};
	endfunction

	// Eight registers only, so dependencies are frequent and $0 is a target
	function automatic isaPkg::regAddr_t pickReg();
		return isaPkg::regAddr_t'(randBits(3));
	endfunction

	function automatic logic [15:0] dataOffset();
		return 16'((DATA_BASE + int'(randBits(5))) * 4);
	endfunction

	function automatic isaPkg::word_t aluInstr(input isaPkg::regAddr_t rs,
		input isaPkg::regAddr_t rt, input isaPkg::regAddr_t rd);
		int sel;
		sel = int'(randBits(3) % 6);
		case (sel)
			0: return encR(rs, rt, rd, isaPkg::FN_ADD);
			1: return encR(rs, rt, rd, isaPkg::FN_SUB);
			2: return encR(rs, rt, rd, isaPkg::FN_AND);
			3: return encR(rs, rt, rd, isaPkg::FN_OR);
			4: return encR(rs, rt, rd, isaPkg::FN_SLT);
			default: return encI(isaPkg::OP_ADDI, rs, rt, 16'(randBits(16)));
		endcase
	endfunction

	// Mode 0 ALU only, 1 adds lw and sw, 2 adds beq
	task automatic genProgram(input int mode);
		int kind;
		int off;
		isaPkg::regAddr_t rs;
		isaPkg::regAddr_t rt;
		isaPkg::regAddr_t rd;
		prog.delete();
		for (int i = 0; i < PROG_LEN - 1; i++)
		begin
			kind = int'(randBits(4));
			rs = pickReg();
			rt = pickReg();
			rd = pickReg();
			if (mode >= 1 && kind < 3)
				prog.push_back(encI(isaPkg::OP_LW, '0, rt, dataOffset()));
			else if (mode >= 1 && kind < 6)
				prog.push_back(encI(isaPkg::OP_SW, '0, rt, dataOffset()));
			else if (mode == 2 && kind < 10)
			begin
				// Equal operands half the time, so plenty are taken
				if (randBits(1) == 1)
					rt = rs;
				off = int'(randBits(2));
				// Forward only, never past the halt
				if (i + 1 + off > PROG_LEN - 1)
					off = PROG_LEN - 2 - i;
				prog.push_back(encI(isaPkg::OP_BEQ, rs, rt, 16'(off)));
			end
			else
				prog.push_back(aluInstr(rs, rt, rd));
		end
		// Halt, beq $0,$0,-1
		prog.push_back(encI(isaPkg::OP_BEQ, '0, '0, 16'hffff));
	endtask

	// ---------------------------------------------------------------------------
	// ISA model
	// ---------------------------------------------------------------------------

	task automatic modelWrite(input isaPkg::regAddr_t r, input isaPkg::word_t v);
		if (r != '0)
		begin
			modelRegs[r] = v;
			expReg.push_back(r);
			expData.push_back(v);
		end
	endtask

	// Architectural run up to the halt, no delay slot
	task automatic runModel();
		int pc;
		int idx;
		isaPkg::word_t ins;
		isaPkg::word_t a;
		isaPkg::word_t b;
		isaPkg::word_t simm;
		isaPkg::regAddr_t rt;
		isaPkg::regAddr_t rd;
		pc = 0;
		for (int r = 0; r < 32; r++)
			modelRegs[r] = '0;
		expReg.delete();
		expData.delete();
		while (pc != PROG_LEN - 1)
		begin
			ins = prog[pc];
			a = modelRegs[ins[25:21]];
			b = modelRegs[ins[20:16]];
			rt = ins[20:16];
			rd = ins[15:11];
			simm = {{16{ins[15]}}, ins[15:0]};
			// Base is always $0, so the offset is the byte address
			idx = int'(simm[11:2]) - DATA_BASE;
			pc++;
			case (isaPkg::opcode_t'(ins[31:26]))
				isaPkg::OP_RTYPE:
					case (isaPkg::funct_t'(ins[5:0]))
						isaPkg::FN_ADD: modelWrite(rd, a + b);
						isaPkg::FN_SUB: modelWrite(rd, a - b);
						isaPkg::FN_AND: modelWrite(rd, a & b);
						isaPkg::FN_OR: modelWrite(rd, a | b);
						isaPkg::FN_SLT: modelWrite(rd, ($signed(a) < $signed(b)) ? 32'd1 : 32'd0);
						default: ;
					endcase
				isaPkg::OP_ADDI: modelWrite(rt, a + simm);
				isaPkg::OP_LW: modelWrite(rt, modelMem[idx]);
				isaPkg::OP_SW: modelMem[idx] = b;
				isaPkg::OP_BEQ:
					if (a == b)
						pc = pc + int'(simm);
				default: ;
			endcase
		end
	endtask

	// ---------------------------------------------------------------------------
	// Tests
	// ---------------------------------------------------------------------------

	task automatic memoryTest();
		busPkg::busData_t unused;
		testName = "loaderMem";
		armWatchdog(DATA_WORDS * 2 * 6 + 200);
		for (int k = 0; k < DATA_WORDS; k++)
		begin
			modelMem[k] = randBits(32);
			loaderCycle(1'b1, dataAddr(k), modelMem[k], unused);
		end
		checkDataRegion();
	endtask

	task automatic runProgram(input string name, input int mode);
		busPkg::busData_t unused;
		testName = name;
		genProgram(mode);
		runModel();
		armWatchdog(PROG_LEN * 12 + (PROG_LEN + PAD_WORDS + DATA_WORDS) * 6 + 200);
		applyReset();
		// Zero padding keeps wrong-path fetches after the halt harmless
		for (int i = 0; i < PROG_LEN + PAD_WORDS; i++)
			loaderCycle(1'b1, busPkg::busAddr_t'(i * 4), (i < PROG_LEN) ? prog[i] : '0, unused);
		@(negedge clk);
		start = 1'b1;
		while (expReg.size() != 0)
			@(negedge clk);
		// Self-loop must stay silent
		repeat (QUIET_CYCLES) @(negedge clk);
		start = 1'b0;
		checkDataRegion();
	endtask

	initial
	begin
		reset = 1'b1;
		start = 1'b0;
		loadCyc = 1'b0;
		loadStb = 1'b0;
		loadWe = 1'b0;
		loadAdr = '0;
		loadDatW = '0;
		applyReset();
		memoryTest();
		runProgram("aluOnly", 0);
		runProgram("memMix", 1);
		runProgram("branchMix", 2);
		runProgram("branchMixAgain", 2);
		$display("Test OK");
		$finish;
	end

endmodule

//--- logic/mipsSystem.sv
`timescale 1ns/1ps

module mipsSystem
(
	input logic clk,
	input logic reset,
	input logic start,
	input logic loadCyc,
	input logic loadStb,
	input logic loadWe,
	input busPkg::busAddr_t loadAdr,
	input busPkg::busData_t loadDatW,
	output busPkg::busData_t loadDatR,
	output logic loadAck,
	output logic wbValid,
	output isaPkg::regAddr_t wbReg,
	output isaPkg::word_t wbData
);

	// Fetch master
	logic fetchCyc;
	logic fetchStb;
	busPkg::busAddr_t fetchAdr;
	busPkg::busData_t fetchDatR;
	logic fetchAck;

	// Data master
	logic dataCyc;
	logic dataStb;
	logic dataWe;
	busPkg::busAddr_t dataAdr;
	busPkg::busData_t dataDatW;
	busPkg::busData_t dataDatR;
	logic dataAck;

	// Slave side
	logic memCyc;
	logic memStb;
	logic memWe;
	busPkg::busAddr_t memAdr;
	busPkg::busData_t memDatW;
	busPkg::busData_t memDatR;
	logic memAck;

	pipeCore pipeCore_i
	(
		.clk(clk),
		.reset(reset),
		.start(start),
		.fetchCyc(fetchCyc),
		.fetchStb(fetchStb),
		.fetchAdr(fetchAdr),
		.fetchDatR(fetchDatR),
		.fetchAck(fetchAck),
		.dataCyc(dataCyc),
		.dataStb(dataStb),
		.dataWe(dataWe),
		.dataAdr(dataAdr),
		.dataDatW(dataDatW),
		.dataDatR(dataDatR),
		.dataAck(dataAck),
		.wbValid(wbValid),
		.wbReg(wbReg),
		.wbData(wbData)
	);

	// Loader first, then data, then fetch
	busArbiter busArbiter_i
	(
		.clk(clk),
		.reset(reset),
		.loadCyc(loadCyc),
		.loadStb(loadStb),
		.loadWe(loadWe),
		.loadAdr(loadAdr),
		.loadDatW(loadDatW),
		.loadDatR(loadDatR),
		.loadAck(loadAck),
		.dataCyc(dataCyc),
		.dataStb(dataStb),
		.dataWe(dataWe),
		.dataAdr(dataAdr),
		.dataDatW(dataDatW),
		.dataDatR(dataDatR),
		.dataAck(dataAck),
		// Fetch only reads
		.fetchCyc(fetchCyc),
		.fetchStb(fetchStb),
		.fetchWe(1'b0),
		.fetchAdr(fetchAdr),
		.fetchDatW('0),
		.fetchDatR(fetchDatR),
		.fetchAck(fetchAck),
		.memCyc(memCyc),
		.memStb(memStb),
		.memWe(memWe),
		.memAdr(memAdr),
		.memDatW(memDatW),
		.memDatR(memDatR),
		.memAck(memAck)
	);

	sharedMemory sharedMemory_i
	(
		.clk(clk),
		.reset(reset),
		.cyc(memCyc),
		.stb(memStb),
		.we(memWe),
		.adr(memAdr),
		.datW(memDatW),
		.datR(memDatR),
		.ack(memAck)
	);

endmodule

//--- logic/pipeCore.sv
`timescale 1ns/1ps
`include "mipsConfig_config.svh"

module pipeCore
(
	input logic clk,
	input logic reset,
	input logic start,
	output logic fetchCyc,
	output logic fetchStb,
	output busPkg::busAddr_t fetchAdr,
	input busPkg::busData_t fetchDatR,
	input logic fetchAck,
	output logic dataCyc,
	output logic dataStb,
	output logic dataWe,
	output busPkg::busAddr_t dataAdr,
	output busPkg::busData_t dataDatW,
	input busPkg::busData_t dataDatR,
	input logic dataAck,
	output logic wbValid,
	output isaPkg::regAddr_t wbReg,
	output isaPkg::word_t wbData
);

	typedef enum logic
	{
		D_IDLE,
		D_BUS
	} dataState_t;

	// Fetch and hazards
	isaPkg::word_t instrF;
	busPkg::busAddr_t instrPcF;
	logic instrValidF;
	logic stallF;
	logic stallD;
	logic flushD;
	logic flushE;
	logic freeze;
	logic memBusy;
	isaPkg::fwdSel_t forwardAD;
	isaPkg::fwdSel_t forwardBD;
	isaPkg::fwdSel_t forwardAE;
	isaPkg::fwdSel_t forwardBE;

	// Decode
	logic validD;
	isaPkg::word_t instrD;
	busPkg::busAddr_t pcD;
	isaPkg::word_t signImmD;
	logic regWriteD;
	logic memToRegD;
	logic memWriteD;
	logic memReadD;
	logic aluSrcImmD;
	logic regDstRdD;
	logic branchD;
	isaPkg::aluOp_t aluOpD;
	isaPkg::word_t rd1D;
	isaPkg::word_t rd2D;
	isaPkg::word_t srcAD;
	isaPkg::word_t srcBD;
	logic pcSrcD;
	busPkg::busAddr_t branchTargetD;

	// Execute
	logic regWriteE;
	logic memToRegE;
	logic memWriteE;
	logic memReadE;
	logic aluSrcImmE;
	logic regDstRdE;
	isaPkg::aluOp_t aluOpE;
	isaPkg::word_t rd1E;
	isaPkg::word_t rd2E;
	isaPkg::regAddr_t rsE;
	isaPkg::regAddr_t rtE;
	isaPkg::regAddr_t rdE;
	isaPkg::word_t immE;
	isaPkg::regAddr_t writeRegE;
	isaPkg::word_t srcAE;
	isaPkg::word_t writeDataE;
	isaPkg::word_t srcBE;
	isaPkg::word_t aluOutE;

	// Memory and write-back
	logic regWriteM;
	logic memToRegM;
	logic memWriteM;
	logic memReadM;
	isaPkg::word_t aluOutM;
	isaPkg::word_t writeDataM;
	isaPkg::regAddr_t writeRegM;
	dataState_t dataState;
	logic regWriteW;
	logic memToRegW;
	logic wbFresh;
	isaPkg::word_t aluOutW;
	isaPkg::word_t readDataW;
	isaPkg::regAddr_t writeRegW;
	isaPkg::word_t resultW;

	// Shared by every forwarding mux
	function automatic isaPkg::word_t fwdMux(isaPkg::fwdSel_t sel, isaPkg::word_t regVal,
		isaPkg::word_t memVal, isaPkg::word_t wbVal);
		case (sel)
			isaPkg::FWD_MEM: return memVal;
			isaPkg::FWD_WB: return wbVal;
			default: return regVal;
		endcase
	endfunction

	// ---------------------------------------------------------------------------
	// Fetch
	// ---------------------------------------------------------------------------

	fetchUnit fetchUnit_i
	(
		.clk(clk),
		.reset(reset),
		.start(start),
		.stall(stallF || freeze),
		.redirect(pcSrcD),
		.redirectPc(branchTargetD),
		.cyc(fetchCyc),
		.stb(fetchStb),
		.adr(fetchAdr),
		.datR(fetchDatR),
		.ack(fetchAck),
		.instr(instrF),
		.instrPc(instrPcF),
		.instrValid(instrValidF)
	);

	// ---------------------------------------------------------------------------
	// Decode and branch resolution
	// ---------------------------------------------------------------------------

	controlUnit controlUnit_i
	(
		.opcode(isaPkg::opcode_t'(instrD[31:26])),
		.funct(isaPkg::funct_t'(instrD[5:0])),
		.regWrite(regWriteD),
		.memToReg(memToRegD),
		.memWrite(memWriteD),
		.memRead(memReadD),
		.aluSrcImm(aluSrcImmD),
		.regDstRd(regDstRdD),
		.branch(branchD),
		.aluOp(aluOpD)
	);

	registerFile registerFile_i
	(
		.clk(clk),
		.reset(reset),
		.ra1(instrD[25:21]),
		.ra2(instrD[20:16]),
		.wa(writeRegW),
		.wd(resultW),
		.we(regWriteW),
		.rd1(rd1D),
		.rd2(rd2D)
	);

	assign signImmD = {{16{instrD[15]}}, instrD[15:0]};

	// Compare with operands forwarded from memory
	assign srcAD = (forwardAD == isaPkg::FWD_MEM) ? aluOutM : rd1D;
	assign srcBD = (forwardBD == isaPkg::FWD_MEM) ? aluOutM : rd2D;

	// Target is PC+4 plus word offset
	assign branchTargetD = pcD + busPkg::busAddr_t'(4) + {signImmD[`MEM_ADDR_BITS-3:0], 2'b00};

	// Taken only when decode really advances
	assign pcSrcD = branchD && validD && (srcAD == srcBD) && !stallD && !freeze;
	assign flushD = pcSrcD;

	// ---------------------------------------------------------------------------
	// Execute
	// ---------------------------------------------------------------------------

	assign writeRegE = regDstRdE ? rdE : rtE;
	assign srcAE = fwdMux(forwardAE, rd1E, aluOutM, resultW);
	assign writeDataE = fwdMux(forwardBE, rd2E, aluOutM, resultW);
	assign srcBE = aluSrcImmE ? immE : writeDataE;

	always_comb
	begin
		case (aluOpE)
			isaPkg::ALU_SUB: aluOutE = srcAE - srcBE;
			isaPkg::ALU_AND: aluOutE = srcAE & srcBE;
			isaPkg::ALU_OR: aluOutE = srcAE | srcBE;
			isaPkg::ALU_SLT: aluOutE = ($signed(srcAE) < $signed(srcBE)) ? 32'd1 : 32'd0;
			default: aluOutE = srcAE + srcBE;
		endcase
	end

	// ---------------------------------------------------------------------------
	// Data port and write-back
	// ---------------------------------------------------------------------------

	// One bus cycle per lw or sw, pipeline frozen until ack
	assign dataCyc = (dataState == D_BUS);
	assign dataStb = dataCyc;
	assign dataWe = memWriteM;
	assign dataAdr = aluOutM[`MEM_ADDR_BITS-1:0];
	assign dataDatW = writeDataM;
	assign memBusy = (memReadM || memWriteM) && !(dataState == D_BUS && dataAck);

	assign resultW = memToRegW ? readDataW : aluOutW;

	// Report once even if write-back is held by a freeze
	assign wbValid = wbFresh && regWriteW && (writeRegW != '0);
	assign wbReg = writeRegW;
	assign wbData = resultW;

	hazardUnit hazardUnit_i
	(
		.rsD(instrD[25:21]),
		.rtD(instrD[20:16]),
		.rsE(rsE),
		.rtE(rtE),
		.writeRegE(writeRegE),
		.writeRegM(writeRegM),
		.writeRegW(writeRegW),
		.branchD(branchD && validD),
		.regWriteE(regWriteE),
		.memToRegE(memToRegE),
		.regWriteM(regWriteM),
		.memToRegM(memToRegM),
		.regWriteW(regWriteW),
		.memBusy(memBusy),
		.stallF(stallF),
		.stallD(stallD),
		.flushE(flushE),
		.freeze(freeze),
		.forwardAD(forwardAD),
		.forwardBD(forwardBD),
		.forwardAE(forwardAE),
		.forwardBE(forwardBE)
	);

	// ---------------------------------------------------------------------------
	// Stage registers
	// ---------------------------------------------------------------------------

	// Valid and control bits
	always_ff @(posedge clk)
	begin
		if (reset)
		begin
			validD <= 1'b0;
			regWriteE <= 1'b0;
			memToRegE <= 1'b0;
			memWriteE <= 1'b0;
			memReadE <= 1'b0;
			regWriteM <= 1'b0;
			memToRegM <= 1'b0;
			memWriteM <= 1'b0;
			memReadM <= 1'b0;
			regWriteW <= 1'b0;
			memToRegW <= 1'b0;
			wbFresh <= 1'b0;
			dataState <= D_IDLE;
		end
		else
		begin
			if (!freeze && !stallD)
				validD <= instrValidF && !flushD;
			if (!freeze)
			begin
				// Bubble into execute on a decode stall
				regWriteE <= regWriteD && validD && !flushE;
				memToRegE <= memToRegD && validD && !flushE;
				memWriteE <= memWriteD && validD && !flushE;
				memReadE <= memReadD && validD && !flushE;
				regWriteM <= regWriteE;
				memToRegM <= memToRegE;
				memWriteM <= memWriteE;
				memReadM <= memReadE;
				regWriteW <= regWriteM;
				memToRegW <= memToRegM;
			end
			wbFresh <= !freeze;
			case (dataState)
				D_IDLE:
					if (memReadM || memWriteM)
						dataState <= D_BUS;
				default:
					if (dataAck)
						dataState <= D_IDLE;
			endcase
		end
	end

	// Payload
	always_ff @(posedge clk)
	begin
		if (!freeze && !stallD)
		begin
			instrD <= (instrValidF && !flushD) ? instrF : '0;
			pcD <= instrPcF;
		end
		if (!freeze)
		begin
			aluSrcImmE <= aluSrcImmD;
			regDstRdE <= regDstRdD;
			aluOpE <= aluOpD;
			rd1E <= rd1D;
			rd2E <= rd2D;
			rsE <= instrD[25:21];
			rtE <= instrD[20:16];
			rdE <= instrD[15:11];
			immE <= signImmD;
			aluOutM <= aluOutE;
			writeDataM <= writeDataE;
			writeRegM <= writeRegE;
			aluOutW <= aluOutM;
			readDataW <= dataDatR;
			writeRegW <= writeRegM;
		end
	end

	// Request held steady until the memory answers
	assert property (@(posedge clk) disable iff (reset)
		(dataStb && !dataAck) |=> $stable(dataAdr) && $stable(dataWe) && $stable(dataDatW));

endmodule

//--- logic/sharedMemory.sv
`timescale 1ns/1ps
`include "mipsConfig_config.svh"

module sharedMemory
(
	input logic clk,
	input logic reset,
	input logic cyc,
	input logic stb,
	input logic we,
	input busPkg::busAddr_t adr,
	input busPkg::busData_t datW,
	output busPkg::busData_t datR,
	output logic ack
);

	busPkg::busData_t mem [`MEM_WORDS];
	logic [`MEM_ADDR_BITS-3:0] wordIdx;

	// Byte address to word index
	assign wordIdx = adr[`MEM_ADDR_BITS-1:2];

	// One ack per request, never back to back
	always_ff @(posedge clk)
	begin
		if (reset)
			ack <= 1'b0;
		else
			ack <= cyc && stb && !ack;
	end

	// Read data ready with ack, write lands on the ack cycle
	always_ff @(posedge clk)
	begin
		if (cyc && stb && !ack)
			datR <= mem[wordIdx];
		if (ack && we)
			mem[wordIdx] <= datW;
	end

	// Master keeps its request up through ack
	assert property (@(posedge clk) disable iff (reset) ack |-> cyc && stb);

endmodule

//--- logic/busArbiter.sv
`timescale 1ns/1ps

module busArbiter
(
	input logic clk,
	input logic reset,
	// Loader master
	input logic loadCyc,
	input logic loadStb,
	input logic loadWe,
	input busPkg::busAddr_t loadAdr,
	input busPkg::busData_t loadDatW,
	output busPkg::busData_t loadDatR,
	output logic loadAck,
	// Core data master
	input logic dataCyc,
	input logic dataStb,
	input logic dataWe,
	input busPkg::busAddr_t dataAdr,
	input busPkg::busData_t dataDatW,
	output busPkg::busData_t dataDatR,
	output logic dataAck,
	// Instruction fetch master
	input logic fetchCyc,
	input logic fetchStb,
	input logic fetchWe,
	input busPkg::busAddr_t fetchAdr,
	input busPkg::busData_t fetchDatW,
	output busPkg::busData_t fetchDatR,
	output logic fetchAck,
	// Memory slave
	output logic memCyc,
	output logic memStb,
	output logic memWe,
	output busPkg::busAddr_t memAdr,
	output busPkg::busData_t memDatW,
	input busPkg::busData_t memDatR,
	input logic memAck
);

	busPkg::grant_t grant;
	busPkg::grant_t nextGrant;
	logic ownerCyc;

	// ---------------------------------------------------------------------------
	// Grant selection
	// ---------------------------------------------------------------------------

	always_comb
	begin
		case (grant)
			busPkg::GRANT_LOADER: ownerCyc = loadCyc;
			busPkg::GRANT_DATA: ownerCyc = dataCyc;
			busPkg::GRANT_FETCH: ownerCyc = fetchCyc;
			default: ownerCyc = 1'b0;
		endcase
	end

	// Held for the whole cycle, fixed priority on release
	always_comb
	begin
		nextGrant = grant;
		if (!ownerCyc)
		begin
			if (loadCyc)
				nextGrant = busPkg::GRANT_LOADER;
			else if (dataCyc)
				nextGrant = busPkg::GRANT_DATA;
			else if (fetchCyc)
				nextGrant = busPkg::GRANT_FETCH;
			else
				nextGrant = busPkg::GRANT_NONE;
		end
	end

	always_ff @(posedge clk)
	begin
		if (reset)
			grant <= busPkg::GRANT_NONE;
		else
			grant <= nextGrant;
	end

	// ---------------------------------------------------------------------------
	// Routing
	// ---------------------------------------------------------------------------

	// Slave sees only the owner
	always_comb
	begin
		memCyc = 1'b0;
		memStb = 1'b0;
		memWe = 1'b0;
		memAdr = loadAdr;
		memDatW = loadDatW;
		case (grant)
			busPkg::GRANT_LOADER:
			begin
				memCyc = loadCyc;
				memStb = loadStb;
				memWe = loadWe;
			end
			busPkg::GRANT_DATA:
			begin
				memCyc = dataCyc;
				memStb = dataStb;
				memWe = dataWe;
				memAdr = dataAdr;
				memDatW = dataDatW;
			end
			busPkg::GRANT_FETCH:
			begin
				memCyc = fetchCyc;
				memStb = fetchStb;
				memWe = fetchWe;
				memAdr = fetchAdr;
				memDatW = fetchDatW;
			end
			default:
				memCyc = 1'b0;
		endcase
	end

	// Return path gated by grant
	assign loadAck = (grant == busPkg::GRANT_LOADER) && memAck;
	assign dataAck = (grant == busPkg::GRANT_DATA) && memAck;
	assign fetchAck = (grant == busPkg::GRANT_FETCH) && memAck;
	assign loadDatR = (grant == busPkg::GRANT_LOADER) ? memDatR : '0;
	assign dataDatR = (grant == busPkg::GRANT_DATA) ? memDatR : '0;
	assign fetchDatR = (grant == busPkg::GRANT_FETCH) ? memDatR : '0;

	// Ack answers a request of the same owner
	assert property (@(posedge clk) disable iff (reset)
		memAck |-> $past(memCyc && memStb) && grant == $past(grant));

endmodule

//--- logic/hazardUnit.sv
`timescale 1ns/1ps

module hazardUnit
(
	input isaPkg::regAddr_t rsD,
	input isaPkg::regAddr_t rtD,
	input isaPkg::regAddr_t rsE,
	input isaPkg::regAddr_t rtE,
	input isaPkg::regAddr_t writeRegE,
	input isaPkg::regAddr_t writeRegM,
	input isaPkg::regAddr_t writeRegW,
	input logic branchD,
	input logic regWriteE,
	input logic memToRegE,
	input logic regWriteM,
	input logic memToRegM,
	input logic regWriteW,
	input logic memBusy,
	output logic stallF,
	output logic stallD,
	output logic flushE,
	output logic freeze,
	output isaPkg::fwdSel_t forwardAD,
	output isaPkg::fwdSel_t forwardBD,
	output isaPkg::fwdSel_t forwardAE,
	output isaPkg::fwdSel_t forwardBE
);

	logic lwStall;
	logic branchStall;

	// Nearest producer wins, never for $0
	function automatic isaPkg::fwdSel_t pickFwd(isaPkg::regAddr_t src, logic enM,
		isaPkg::regAddr_t wrM, logic enW, isaPkg::regAddr_t wrW);
		if (src != '0 && enM && wrM == src)
			return isaPkg::FWD_MEM;
		else if (src != '0 && enW && wrW == src)
			return isaPkg::FWD_WB;
		return isaPkg::FWD_NONE;
	endfunction

	// Destination read by the decode instruction
	function automatic logic readsD(isaPkg::regAddr_t wr);
		return (wr != '0) && (wr == rsD || wr == rtD);
	endfunction

	// Execute takes memory or write-back results
	assign forwardAE = pickFwd(rsE, regWriteM, writeRegM, regWriteW, writeRegW);
	assign forwardBE = pickFwd(rtE, regWriteM, writeRegM, regWriteW, writeRegW);

	// Decode only needs memory, write-back goes through the register file
	assign forwardAD = pickFwd(rsD, regWriteM, writeRegM, 1'b0, writeRegW);
	assign forwardBD = pickFwd(rtD, regWriteM, writeRegM, 1'b0, writeRegW);

	// Load in execute feeding the next instruction
	assign lwStall = memToRegE && readsD(writeRegE);

	// Branch operands not yet available in decode
	assign branchStall = branchD && ((regWriteE && readsD(writeRegE)) ||
		(memToRegM && readsD(writeRegM)));

	assign stallF = lwStall || branchStall;
	assign stallD = stallF;
	assign flushE = stallD;

	// Data port owns the pipeline until its ack
	assign freeze = memBusy;

endmodule

//--- logic/registerFile.sv
`timescale 1ns/1ps

module registerFile
(
	input logic clk,
	input logic reset,
	input isaPkg::regAddr_t ra1,
	input isaPkg::regAddr_t ra2,
	input isaPkg::regAddr_t wa,
	input isaPkg::word_t wd,
	input logic we,
	output isaPkg::word_t rd1,
	output isaPkg::word_t rd2
);

	isaPkg::word_t regs [32];

	// Architectural state starts at zero
	always_ff @(posedge clk)
	begin
		if (reset)
		begin
			for (int i = 0; i < 32; i++)
				regs[i] <= '0;
		end
		else if (we && wa != '0)
			regs[wa] <= wd;
	end

	// $0 hardwired, write-through for the retiring value
	assign rd1 = (ra1 == '0) ? '0 : (we && ra1 == wa) ? wd : regs[ra1];
	assign rd2 = (ra2 == '0) ? '0 : (we && ra2 == wa) ? wd : regs[ra2];

endmodule

//--- logic/controlUnit.sv
`timescale 1ns/1ps

module controlUnit
(
	input isaPkg::opcode_t opcode,
	input isaPkg::funct_t funct,
	output logic regWrite,
	output logic memToReg,
	output logic memWrite,
	output logic memRead,
	output logic aluSrcImm,
	output logic regDstRd,
	output logic branch,
	output isaPkg::aluOp_t aluOp
);

	always_comb
	begin
		// Anything not listed decodes as a no-op
		regWrite = 1'b0;
		memToReg = 1'b0;
		memWrite = 1'b0;
		memRead = 1'b0;
		aluSrcImm = 1'b0;
		regDstRd = 1'b0;
		branch = 1'b0;
		aluOp = isaPkg::ALU_ADD;

		case (opcode)
			isaPkg::OP_RTYPE:
			begin
				regDstRd = 1'b1;
				regWrite = 1'b1;
				case (funct)
					isaPkg::FN_ADD: aluOp = isaPkg::ALU_ADD;
					isaPkg::FN_SUB: aluOp = isaPkg::ALU_SUB;
					isaPkg::FN_AND: aluOp = isaPkg::ALU_AND;
					isaPkg::FN_OR: aluOp = isaPkg::ALU_OR;
					isaPkg::FN_SLT: aluOp = isaPkg::ALU_SLT;
					// Unknown funct, nothing retires
					default: regWrite = 1'b0;
				endcase
			end
			isaPkg::OP_ADDI:
			begin
				regWrite = 1'b1;
				aluSrcImm = 1'b1;
			end
			// Address is base plus offset
			isaPkg::OP_LW:
			begin
				regWrite = 1'b1;
				memToReg = 1'b1;
				memRead = 1'b1;
				aluSrcImm = 1'b1;
			end
			isaPkg::OP_SW:
			begin
				memWrite = 1'b1;
				aluSrcImm = 1'b1;
			end
			// Compare happens in decode, ALU result unused
			isaPkg::OP_BEQ:
			begin
				branch = 1'b1;
				aluOp = isaPkg::ALU_SUB;
			end
			default:
				branch = 1'b0;
		endcase
	end

endmodule

//--- logic/fetchUnit.sv
`timescale 1ns/1ps

module fetchUnit
(
	input logic clk,
	input logic reset,
	input logic start,
	input logic stall,
	input logic redirect,
	input busPkg::busAddr_t redirectPc,
	output logic cyc,
	output logic stb,
	output busPkg::busAddr_t adr,
	input busPkg::busData_t datR,
	input logic ack,
	output isaPkg::word_t instr,
	output busPkg::busAddr_t instrPc,
	output logic instrValid
);

	typedef enum logic [1:0]
	{
		F_IDLE,
		F_REQ,
		F_DISCARD
	} fetchState_t;

	fetchState_t state;
	busPkg::busAddr_t pc;
	busPkg::busAddr_t reqAdr;
	logic launch;
	logic accept;

	// One word buffer, new request only once it is free
	assign launch = start && !redirect && (!instrValid || !stall);
	assign accept = (state == F_REQ) && ack && !redirect;

	// Cycle and strobe move together
	assign cyc = (state != F_IDLE);
	assign stb = cyc;
	assign adr = reqAdr;

	always_ff @(posedge clk)
	begin
		if (reset)
		begin
			state <= F_IDLE;
			pc <= '0;
			instrValid <= 1'b0;
		end
		else
		begin
			case (state)
				F_IDLE:
					if (launch)
						state <= F_REQ;
				F_REQ:
					if (ack)
						state <= F_IDLE;
					else if (redirect)
						state <= F_DISCARD;
				// Wrong-path word still owed by the bus
				default:
					if (ack)
						state <= F_IDLE;
			endcase

			// Redirect wins over a word landing the same cycle
			if (redirect)
			begin
				pc <= redirectPc;
				instrValid <= 1'b0;
			end
			else if (accept)
			begin
				pc <= pc + busPkg::busAddr_t'(4);
				instrValid <= 1'b1;
			end
			else if (instrValid && !stall)
				instrValid <= 1'b0;
		end
	end

	// Address frozen for the whole bus cycle
	always_ff @(posedge clk)
	begin
		if (state == F_IDLE)
			reqAdr <= pc;
		if (accept)
		begin
			instr <= datR;
			instrPc <= reqAdr;
		end
	end

endmodule

//--- logic/busPkg.sv
`include "mipsConfig_config.svh"

package busPkg;

	// Word-aligned byte address
	typedef logic [`MEM_ADDR_BITS-1:0] busAddr_t;

	// Bus data word
	typedef logic [31:0] busData_t;

	// Current bus owner, also the arbiter state
	typedef enum logic [1:0]
	{
		GRANT_NONE,
		GRANT_LOADER,
		GRANT_DATA,
		GRANT_FETCH
	} grant_t;

endpackage

//--- logic/isaPkg.sv
package isaPkg;

	// Data path widths
	typedef logic [31:0] word_t;
	typedef logic [4:0] regAddr_t;

	// Instruction fields
	typedef logic [5:0] opcode_t;
	typedef logic [5:0] funct_t;

	// Primary opcodes
	localparam opcode_t OP_RTYPE = 6'h00;
	localparam opcode_t OP_BEQ = 6'h04;
	localparam opcode_t OP_ADDI = 6'h08;
	localparam opcode_t OP_LW = 6'h23;
	localparam opcode_t OP_SW = 6'h2b;

	// R-type funct codes
	localparam funct_t FN_ADD = 6'h20;
	localparam funct_t FN_SUB = 6'h22;
	localparam funct_t FN_AND = 6'h24;
	localparam funct_t FN_OR = 6'h25;
	localparam funct_t FN_SLT = 6'h2a;

	// ALU operations
	typedef enum logic [2:0]
	{
		ALU_ADD,
		ALU_SUB,
		ALU_AND,
		ALU_OR,
		ALU_SLT
	} aluOp_t;

	// Operand source of a forwarding mux
	typedef enum logic [1:0]
	{
		FWD_NONE,
		FWD_MEM,
		FWD_WB
	} fwdSel_t;

endpackage

//--- include/mipsConfig_config.svh
`ifndef MIPS_CONFIG_SVH
`define MIPS_CONFIG_SVH

// ---------------------------------------------------------------------------
// Shared memory geometry
// ---------------------------------------------------------------------------

// Byte address width on the bus
`define MEM_ADDR_BITS 12

// Depth of the shared memory in 32-bit words
`define MEM_WORDS 1024

`endif
